// File: rtl/cheat_pkg.sv
// cheat_pkg: widths, table word layout and engine states for the cheat engine
`default_nettype none

package cheat_pkg;

    typedef logic [21:0] addr_t;
    typedef logic [15:0] data_t;
    // set bit leaves that byte untouched
    typedef logic [1:0]  mask_t;
    typedef logic [31:0] flags_t;
    typedef logic [4:0]  flag_idx_t;
    typedef logic [7:0]  prog_byte_t;
    typedef logic [17:0] table_word_t;

    // word 0: last | flag index | mask | addr[21:12]
    localparam int W0_LAST     = 17;
    localparam int W0_FIDX_MSB = 16;
    localparam int W0_FIDX_LSB = 12;
    localparam int W0_MASK_MSB = 11;
    localparam int W0_MASK_LSB = 10;
    localparam int W0_AHI_MSB  = 9;
    localparam int W0_AHI_LSB  = 0;
    // word 1: addr[11:0] on top, low six bits spare
    localparam int W1_ALO_MSB  = 17;
    localparam int W1_ALO_LSB  = 6;
    // word 2: value
    localparam int W2_VAL_MSB  = 15;
    localparam int W2_VAL_LSB  = 0;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ_W0,
        ST_READ_W1,
        ST_READ_W2,
        ST_ISSUE,
        ST_WAIT_CREDIT
    } engine_state_t;

endpackage

`default_nettype wire

// File: rtl/cheat_prog_packer.sv
// cheat_prog_packer: nine host bytes in, four 18-bit table words out
`default_nettype none

module cheat_prog_packer
    import cheat_pkg::*;
#(
    parameter int TABLE_AW = 9
) (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 load_start,
    input  wire                 prog_wr,
    input  wire prog_byte_t     prog_data,
    output logic                word_we,
    output logic [TABLE_AW-1:0] word_addr,
    output table_word_t         word_data
);

    logic [3:0]  byte_cnt;
    logic [3:0]  byte_idx;
    logic [15:0] byte_buf;

    // a byte arriving with load_start opens the new group
    assign byte_idx = load_start ? 4'd0 : byte_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            byte_cnt  <= 4'd0;
            word_we   <= 1'b0;
            word_addr <= '0;
        end else begin
            word_we <= 1'b0;
            if (load_start) begin
                word_addr <= '0;
            end else if (word_we) begin
                word_addr <= word_addr + 1'b1;
            end
            if (prog_wr) begin
                byte_cnt <= (byte_idx == 4'd8) ? 4'd0 : byte_idx + 4'd1;
                // bytes 2, 4, 6 and 8 close a word
                word_we  <= (byte_idx != 4'd0) && !byte_idx[0];
            end else if (load_start) begin
                byte_cnt <= 4'd0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (prog_wr) begin
            byte_buf <= {prog_data, byte_buf[15:8]};
            case (byte_idx)
                4'd2:    word_data <= {prog_data[1:0], byte_buf};
                4'd4:    word_data <= {prog_data[3:0], byte_buf[15:2]};
                4'd6:    word_data <= {prog_data[5:0], byte_buf[15:4]};
                4'd8:    word_data <= {prog_data, byte_buf[15:6]};
                default: word_data <= word_data;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/cheat_table_ram.sv
// cheat_table_ram: simple dual-port cheat table with registered read
`default_nettype none

module cheat_table_ram
    import cheat_pkg::*;
#(
    parameter int TABLE_AW = 9
) (
    input  wire                  clk,
    input  wire                  we,
    input  wire [TABLE_AW-1:0]   wr_addr,
    input  wire table_word_t     wr_data,
    input  wire [TABLE_AW-1:0]   rd_addr,
    output table_word_t          rd_data
);

    table_word_t mem [2**TABLE_AW];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: rtl/cheat_ctrl_regs.sv
// cheat_ctrl_regs: frame and load edge detection, per-frame flags, table length
`default_nettype none

module cheat_ctrl_regs
    import cheat_pkg::*;
#(
    parameter int TABLE_AW = 9
) (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               vblank,
    input  wire               prog_en,
    input  wire flags_t       flags,
    input  wire               word_we,
    output logic              frame_start,
    output logic              load_start,
    output flags_t            frame_flags,
    output logic [TABLE_AW:0] table_len
);

    logic vblank_q;
    logic prog_en_q;
    logic vblank_fall;

    assign vblank_fall = vblank_q && !vblank;
    assign load_start  = prog_en && !prog_en_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vblank_q    <= 1'b0;
            prog_en_q   <= 1'b0;
            frame_start <= 1'b0;
            table_len   <= '0;
        end else begin
            vblank_q    <= vblank;
            prog_en_q   <= prog_en;
            frame_start <= vblank_fall;
            if (load_start) begin
                table_len <= '0;
            end else if (word_we) begin
                table_len <= table_len + 1'b1;
            end
        end
    end

    // flags stay fixed for the whole pass
    always_ff @(posedge clk) begin
        if (vblank_fall) begin
            frame_flags <= flags;
        end
    end

endmodule

`default_nettype wire

// File: rtl/cheat_engine.sv
// cheat_engine: table walker that issues masked writes under one credit
`default_nettype none

module cheat_engine
    import cheat_pkg::*;
#(
    parameter int TABLE_AW = 9
) (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 frame_start,
    input  wire flags_t         frame_flags,
    input  wire [TABLE_AW:0]    table_len,
    output logic [TABLE_AW-1:0] rd_addr,
    input  wire table_word_t    rd_data,
    output logic                cheat_valid,
    output addr_t               cheat_addr,
    output data_t               cheat_din,
    output mask_t               cheat_din_m,
    input  wire                 cheat_credit
);

    engine_state_t     state;
    logic [TABLE_AW:0] ptr;
    logic              credit;
    logic              last_q;
    flag_idx_t         fidx_q;
    logic              hit;
    logic              advance;
    logic              walk_done;

    assign rd_addr   = ptr[TABLE_AW-1:0];
    assign hit       = frame_flags[fidx_q];
    // ptr already points at the next entry here
    assign walk_done = last_q || (ptr >= table_len);
    assign advance   = (state == ST_ISSUE || state == ST_WAIT_CREDIT) && (!hit || credit);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            ptr         <= '0;
            credit      <= 1'b1;
            cheat_valid <= 1'b0;
        end else begin
            cheat_valid <= 1'b0;
            if (cheat_credit) begin
                credit <= 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    // mid-pass frame edges never reach this state
                    if (frame_start && table_len != '0) begin
                        state <= ST_READ_W0;
                    end
                end
                ST_READ_W0: begin
                    ptr   <= ptr + 1'b1;
                    state <= ST_READ_W1;
                end
                ST_READ_W1: begin
                    ptr   <= ptr + 1'b1;
                    state <= ST_READ_W2;
                end
                ST_READ_W2: begin
                    ptr   <= ptr + 1'b1;
                    state <= ST_ISSUE;
                end
                ST_ISSUE, ST_WAIT_CREDIT: begin
                    if (advance) begin
                        if (hit) begin
                            cheat_valid <= 1'b1;
                            credit      <= 1'b0;
                        end
                        if (walk_done) begin
                            state <= ST_IDLE;
                            ptr   <= '0;
                        end else begin
                            state <= ST_READ_W0;
                        end
                    end else begin
                        state <= ST_WAIT_CREDIT;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // entry fields, captured as each word comes out of the table
    always_ff @(posedge clk) begin
        case (state)
            ST_READ_W1: begin
                last_q                  <= rd_data[W0_LAST];
                fidx_q                  <= rd_data[W0_FIDX_MSB:W0_FIDX_LSB];
                cheat_din_m             <= rd_data[W0_MASK_MSB:W0_MASK_LSB];
                cheat_addr[21:12]       <= rd_data[W0_AHI_MSB:W0_AHI_LSB];
            end
            ST_READ_W2: cheat_addr[11:0] <= rd_data[W1_ALO_MSB:W1_ALO_LSB];
            ST_ISSUE:   cheat_din        <= rd_data[W2_VAL_MSB:W2_VAL_LSB];
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/cheat_sdram_arbiter.sv
// cheat_sdram_arbiter: bank 0 sharing between game and cheat engine, game first
`default_nettype none

module cheat_sdram_arbiter
    import cheat_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    // game side
    input  wire addr_t game_addr,
    input  wire        game_rd,
    input  wire        game_wr,
    input  wire data_t game_din,
    input  wire mask_t game_din_m,
    output logic       game_dst,
    output logic       game_rdy,
    // bank 0
    output addr_t      ba0_addr,
    output logic       ba0_rd,
    output logic       ba0_wr,
    output data_t      ba0_din,
    output mask_t      ba0_din_m,
    input  wire        ba0_dst,
    input  wire        ba0_rdy,
    // engine side
    input  wire        cheat_valid,
    input  wire addr_t cheat_addr,
    input  wire data_t cheat_din,
    input  wire mask_t cheat_din_m,
    output logic       cheat_credit
);

    logic  busy;
    // owner high means the engine holds the bank
    logic  owner;
    logic  req_pend;
    addr_t req_addr;
    data_t req_din;
    mask_t req_din_m;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy         <= 1'b0;
            owner        <= 1'b0;
            req_pend     <= 1'b0;
            cheat_credit <= 1'b0;
        end else begin
            cheat_credit <= busy && owner && ba0_rdy;
            if (cheat_valid) begin
                req_pend <= 1'b1;
            end
            if (busy) begin
                if (ba0_rdy) begin
                    busy <= 1'b0;
                end
            end else if (game_rd || game_wr) begin
                busy  <= 1'b1;
                owner <= 1'b0;
            end else if (req_pend) begin
                busy     <= 1'b1;
                owner    <= 1'b1;
                req_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cheat_valid) begin
            req_addr  <= cheat_addr;
            req_din   <= cheat_din;
            req_din_m <= cheat_din_m;
        end
    end

    // engine accesses are writes only
    always_comb begin
        ba0_addr  = owner ? req_addr  : game_addr;
        ba0_rd    = !owner && game_rd;
        ba0_wr    = owner ? busy      : game_wr;
        ba0_din   = owner ? req_din   : game_din;
        ba0_din_m = owner ? req_din_m : game_din_m;
        game_dst  = !owner && ba0_dst;
        game_rdy  = !owner && ba0_rdy;
    end

endmodule

`default_nettype wire

// File: rtl/cheat_top.sv
// cheat_top: cheat engine subsystem between the game core and SDRAM bank 0
`default_nettype none

module cheat_top
    import cheat_pkg::*;
#(
    parameter int TABLE_AW = 9
) (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             vblank,
    input  wire flags_t     flags,
    // host program port
    input  wire             prog_en,
    input  wire             prog_wr,
    input  wire prog_byte_t prog_data,
    // game port, read data comes straight from ba0_data
    input  wire addr_t      game_addr,
    input  wire             game_rd,
    input  wire             game_wr,
    input  wire data_t      game_din,
    input  wire mask_t      game_din_m,
    output logic            game_dst,
    output logic            game_rdy,
    // bank 0
    output addr_t           ba0_addr,
    output logic            ba0_rd,
    output logic            ba0_wr,
    output data_t           ba0_din,
    output mask_t           ba0_din_m,
    input  wire             ba0_dst,
    input  wire             ba0_rdy,
    input  wire data_t      ba0_data
);

    logic                word_we;
    logic [TABLE_AW-1:0] word_addr;
    table_word_t         word_data;
    logic [TABLE_AW-1:0] rd_addr;
    table_word_t         rd_data;
    logic                frame_start;
    logic                load_start;
    flags_t              frame_flags;
    logic [TABLE_AW:0]   table_len;
    logic                cheat_valid;
    addr_t               cheat_addr;
    data_t               cheat_din;
    mask_t               cheat_din_m;
    logic                cheat_credit;

    cheat_prog_packer #(.TABLE_AW(TABLE_AW)) i_packer (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_start (load_start),
        .prog_wr    (prog_wr),
        .prog_data  (prog_data),
        .word_we    (word_we),
        .word_addr  (word_addr),
        .word_data  (word_data)
    );

    cheat_table_ram #(.TABLE_AW(TABLE_AW)) i_table_ram (
        .clk     (clk),
        .we      (word_we),
        .wr_addr (word_addr),
        .wr_data (word_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    cheat_ctrl_regs #(.TABLE_AW(TABLE_AW)) i_ctrl_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .vblank      (vblank),
        .prog_en     (prog_en),
        .flags       (flags),
        .word_we     (word_we),
        .frame_start (frame_start),
        .load_start  (load_start),
        .frame_flags (frame_flags),
        .table_len   (table_len)
    );

    cheat_engine #(.TABLE_AW(TABLE_AW)) i_engine (
        .clk          (clk),
        .rst_n        (rst_n),
        .frame_start  (frame_start),
        .frame_flags  (frame_flags),
        .table_len    (table_len),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .cheat_valid  (cheat_valid),
        .cheat_addr   (cheat_addr),
        .cheat_din    (cheat_din),
        .cheat_din_m  (cheat_din_m),
        .cheat_credit (cheat_credit)
    );

    cheat_sdram_arbiter i_arbiter (
        .clk          (clk),
        .rst_n        (rst_n),
        .game_addr    (game_addr),
        .game_rd      (game_rd),
        .game_wr      (game_wr),
        .game_din     (game_din),
        .game_din_m   (game_din_m),
        .game_dst     (game_dst),
        .game_rdy     (game_rdy),
        .ba0_addr     (ba0_addr),
        .ba0_rd       (ba0_rd),
        .ba0_wr       (ba0_wr),
        .ba0_din      (ba0_din),
        .ba0_din_m    (ba0_din_m),
        .ba0_dst      (ba0_dst),
        .ba0_rdy      (ba0_rdy),
        .cheat_valid  (cheat_valid),
        .cheat_addr   (cheat_addr),
        .cheat_din    (cheat_din),
        .cheat_din_m  (cheat_din_m),
        .cheat_credit (cheat_credit)
    );

endmodule

`default_nettype wire

// File: testbench/cheat_tb.sv
// testbench for the cheat engine: clock, reset, SDRAM model, table loader, reference and checks
`default_nettype none

module cheat_tb
    import cheat_pkg::*;
;

    localparam int TABLE_AW  = 9;
    localparam int MAX_ENT   = 16;
    localparam int MEM_WORDS = 256;
    // engine entries use the low half of the window, game traffic the high half
    localparam int ENT_SPAN  = 128;
    localparam int GAME_LO   = 128;
    localparam addr_t MEM_BASE = 22'h2a_5300;
    // 4 frames of 8, 8, 8 and 4 entries, three loads of 54, 54 and 27 bytes
    localparam int N_FRAME_ENTRIES = 28;
    localparam int LOAD_CYCLES     = 160;
    // margin for reset, vblank pulses, settling and the game traffic tail
    localparam int TIMEOUT_CYCLES  = 40 * N_FRAME_ENTRIES + LOAD_CYCLES + 600;

    logic       clk;
    logic       rst_n;
    logic       vblank;
    flags_t     flags;
    logic       prog_en;
    logic       prog_wr;
    prog_byte_t prog_data;
    addr_t      game_addr;
    logic       game_rd;
    logic       game_wr;
    data_t      game_din;
    mask_t      game_din_m;
    logic       game_dst;
    logic       game_rdy;
    addr_t      ba0_addr;
    logic       ba0_rd;
    logic       ba0_wr;
    data_t      ba0_din;
    mask_t      ba0_din_m;
    logic       ba0_dst;
    logic       ba0_rdy;
    data_t      ba0_data;

    // cheat list of the current table
    addr_t      ent_addr [MAX_ENT];
    data_t      ent_val  [MAX_ENT];
    mask_t      ent_mask [MAX_ENT];
    flag_idx_t  ent_fidx [MAX_ENT];
    logic       ent_last [MAX_ENT];
    int         n_ent;

    data_t      bank_mem [MEM_WORDS];
    data_t      exp_img  [MEM_WORDS];

    // SDRAM model access in flight
    logic       bank_busy;
    logic [1:0] bank_wait;
    logic       acc_rd;
    logic [7:0] acc_idx;
    data_t      acc_din;
    mask_t      acc_m;

    int seed;
    int cycle_cnt  = 0;
    int eng_writes = 0;
    int n_checks   = 0;
    int data_errs  = 0;
    int word_errs  = 0;
    int proto_errs = 0;

    cheat_top #(.TABLE_AW(TABLE_AW)) i_cheat_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .vblank     (vblank),
        .flags      (flags),
        .prog_en    (prog_en),
        .prog_wr    (prog_wr),
        .prog_data  (prog_data),
        .game_addr  (game_addr),
        .game_rd    (game_rd),
        .game_wr    (game_wr),
        .game_din   (game_din),
        .game_din_m (game_din_m),
        .game_dst   (game_dst),
        .game_rdy   (game_rdy),
        .ba0_addr   (ba0_addr),
        .ba0_rd     (ba0_rd),
        .ba0_wr     (ba0_wr),
        .ba0_din    (ba0_din),
        .ba0_din_m  (ba0_din_m),
        .ba0_dst    (ba0_dst),
        .ba0_rdy    (ba0_rdy),
        .ba0_data   (ba0_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // power-up contents, a function of the full address
    function automatic data_t fill_value(addr_t a);
        return a[15:0] ^ {a[21:16], a[9:0]} ^ 16'h5a3c;
    endfunction

    // set mask bit keeps the old byte
    function automatic data_t merge_bytes(data_t old_v, data_t new_v, mask_t m);
        data_t r;
        r = old_v;
        if (!m[1]) r[15:8] = new_v[15:8];
        if (!m[0]) r[7:0] = new_v[7:0];
        return r;
    endfunction

    // reference: word at address a after one pass with flags f
    function automatic data_t expected_word(addr_t a, data_t prev, flags_t f);
        data_t r;
        r = prev;
        for (int k = 0; k < n_ent; k++) begin
            if (f[ent_fidx[k]] && ent_addr[k] == a) begin
                r = merge_bytes(r, ent_val[k], ent_mask[k]);
            end
            if (ent_last[k]) break;
        end
        return r;
    endfunction

    function automatic int count_hits(flags_t f);
        int cnt;
        cnt = 0;
        for (int k = 0; k < n_ent; k++) begin
            if (f[ent_fidx[k]]) cnt++;
            if (ent_last[k]) break;
        end
        return cnt;
    endfunction

    function automatic table_word_t entry_word(int k, int part);
        table_word_t w;
        w = '0;
        case (part)
            0: begin
                w[W0_LAST]                 = ent_last[k];
                w[W0_FIDX_MSB:W0_FIDX_LSB] = ent_fidx[k];
                w[W0_MASK_MSB:W0_MASK_LSB] = ent_mask[k];
                w[W0_AHI_MSB:W0_AHI_LSB]   = ent_addr[k][21:12];
            end
            1: w[W1_ALO_MSB:W1_ALO_LSB] = ent_addr[k][11:0];
            default: w[W2_VAL_MSB:W2_VAL_LSB] = ent_val[k];
        endcase
        return w;
    endfunction

    task automatic check_data(addr_t a, data_t got, data_t exp);
        n_checks++;
        if (got !== exp) begin
            $display("Error at %0t: game read at %h returned %h, expected %h", $time, a, got, exp);
            data_errs++;
        end
    endtask

    task automatic check_word(addr_t a, data_t got, data_t exp);
        n_checks++;
        if (got !== exp) begin
            $display("Error at %0t: memory at %h holds %h, expected %h", $time, a, got, exp);
            word_errs++;
        end
    endtask

    task automatic make_entries(int n, int last_at);
        n_ent = n;
        for (int k = 0; k < n; k++) begin
            ent_addr[k] = MEM_BASE + addr_t'($random(seed) & 127);
            ent_val[k]  = data_t'($random(seed));
            ent_mask[k] = mask_t'($random(seed));
            ent_fidx[k] = flag_idx_t'($random(seed));
            ent_last[k] = (k == last_at);
        end
    endtask

    // entry count must give whole groups of four words
    task automatic load_table();
        logic [71:0] grp;
        int          w;
        @(posedge clk);
        prog_en <= 1'b1;
        for (int g = 0; g < n_ent * 3 / 4; g++) begin
            for (int j = 0; j < 4; j++) begin
                w = 4 * g + j;
                grp[18*j +: 18] = entry_word(w / 3, w % 3);
            end
            // low bits of the group go out first
            for (int b = 0; b < 9; b++) begin
                @(posedge clk);
                prog_wr   <= 1'b1;
                prog_data <= grp[8*b +: 8];
            end
        end
        @(posedge clk);
        prog_wr <= 1'b0;
        prog_en <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    task automatic game_traffic(int n);
        int    off;
        logic  is_wr;
        data_t v;
        mask_t m;
        for (int k = 0; k < n; k++) begin
            repeat ($random(seed) & 3) @(posedge clk);
            off   = GAME_LO + ($random(seed) & 127);
            is_wr = $random(seed) & 1;
            v     = data_t'($random(seed));
            m     = mask_t'($random(seed));
            @(posedge clk);
            game_addr  <= MEM_BASE + addr_t'(off);
            game_rd    <= !is_wr;
            game_wr    <= is_wr;
            game_din   <= v;
            game_din_m <= m;
            @(posedge clk);
            while (!game_rdy) @(posedge clk);
            if (is_wr) begin
                exp_img[off] = merge_bytes(exp_img[off], v, m);
            end else begin
                if (!game_dst) begin
                    $display("game read at %h completed without game_dst", MEM_BASE + addr_t'(off));
                    proto_errs++;
                end
                check_data(MEM_BASE + addr_t'(off), ba0_data, exp_img[off]);
            end
            game_rd <= 1'b0;
            game_wr <= 1'b0;
        end
    endtask

    // one vblank edge with flags f, changed to f_mid once latched
    task automatic run_frame(flags_t f, flags_t f_mid, int game_ops);
        int base;
        int hits;
        base = eng_writes;
        hits = count_hits(f);
        @(posedge clk);
        flags  <= f;
        vblank <= 1'b0;
        fork
            begin
                @(posedge clk);
                flags <= f_mid;
                repeat (8) @(posedge clk);
                vblank <= 1'b1;
                while (eng_writes - base < hits) @(posedge clk);
            end
            game_traffic(game_ops);
        join
        repeat (30) @(posedge clk);
        if (eng_writes - base != hits) begin
            $display("engine made %0d bank writes in this frame instead of %0d",
                     eng_writes - base, hits);
            proto_errs++;
        end
        for (int i = 0; i < ENT_SPAN; i++) begin
            exp_img[i] = expected_word(MEM_BASE + addr_t'(i), exp_img[i], f);
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_word(MEM_BASE + addr_t'(i), bank_mem[i], exp_img[i]);
        end
    endtask

    // bank 0 model, answers 1 to 4 cycles after the request
    always @(posedge clk) begin
        ba0_rdy <= 1'b0;
        ba0_dst <= 1'b0;
        if (!rst_n) begin
            bank_busy <= 1'b0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                bank_mem[i] <= fill_value(MEM_BASE + addr_t'(i));
            end
        end else if (!bank_busy) begin
            // requester drops its request on the cycle after rdy
            if ((ba0_rd || ba0_wr) && !ba0_rdy) begin
                if (ba0_addr[21:8] != MEM_BASE[21:8]) begin
                    $display("bank access at %h falls outside the modeled memory", ba0_addr);
                    proto_errs++;
                end
                bank_busy <= 1'b1;
                bank_wait <= 2'($random(seed) & 3);
                acc_rd    <= ba0_rd;
                acc_idx   <= ba0_addr[7:0];
                acc_din   <= ba0_din;
                acc_m     <= ba0_din_m;
            end
        end else if (bank_wait != 2'd0) begin
            bank_wait <= bank_wait - 2'd1;
        end else begin
            bank_busy <= 1'b0;
            ba0_rdy   <= 1'b1;
            ba0_dst   <= acc_rd;
            if (acc_rd) begin
                ba0_data <= bank_mem[acc_idx];
            end else begin
                if (!acc_m[1]) bank_mem[acc_idx][15:8] <= acc_din[15:8];
                if (!acc_m[0]) bank_mem[acc_idx][7:0] <= acc_din[7:0];
            end
        end
    end

    // bank completions that the game does not see belong to the engine
    always @(posedge clk) begin
        if (rst_n) begin
            if (ba0_rdy && !game_rdy) eng_writes++;
            if (game_rdy && !game_rd && !game_wr) begin
                $display("game_rdy seen while the game had no request");
                proto_errs++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        flags_t f_next;
        seed       = 32'haf5d_a19c;
        rst_n      = 1'b0;
        vblank     = 1'b1;
        flags      = '0;
        prog_en    = 1'b0;
        prog_wr    = 1'b0;
        prog_data  = '0;
        game_addr  = '0;
        game_rd    = 1'b0;
        game_wr    = 1'b0;
        game_din   = '0;
        game_din_m = '0;
        ba0_dst    = 1'b0;
        ba0_rdy    = 1'b0;
        ba0_data   = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            exp_img[i] = fill_value(MEM_BASE + addr_t'(i));
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);

        // full table, random flags, game traffic during the pass
        make_entries(8, -1);
        load_table();
        if (eng_writes != 0) begin
            $display("cheat write reached the bank before any frame start");
            proto_errs++;
        end
        f_next = flags_t'($random(seed));
        run_frame(flags_t'($random(seed)), f_next, 12);
        // mid-pass flags only apply from this frame on
        run_frame(f_next, flags_t'($random(seed)), 6);

        // third entry ends the walk
        make_entries(8, 2);
        load_table();
        run_frame(32'hffff_ffff, flags_t'($random(seed)), 0);

        // shorter table replaces the old one
        make_entries(4, -1);
        load_table();
        run_frame(32'hffff_ffff, flags_t'($random(seed)), 8);

        $display("checks %0d, data errors %0d, image errors %0d, other errors %0d",
                 n_checks, data_errs, word_errs, proto_errs);
        if (data_errs == 0 && word_errs == 0 && proto_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
rtl/cheat_pkg.sv
rtl/cheat_prog_packer.sv
rtl/cheat_table_ram.sv
rtl/cheat_ctrl_regs.sv
rtl/cheat_engine.sv
rtl/cheat_sdram_arbiter.sv
rtl/cheat_top.sv
testbench/cheat_tb.sv

// File: Bender.yml
package:
  name: cheat_engine

sources:
  - rtl/cheat_pkg.sv
  - rtl/cheat_prog_packer.sv
  - rtl/cheat_table_ram.sv
  - rtl/cheat_ctrl_regs.sv
  - rtl/cheat_engine.sv
  - rtl/cheat_sdram_arbiter.sv
  - rtl/cheat_top.sv
  - target: test
    files:
      - testbench/cheat_tb.sv
